// File: design/pipe_pkg.sv
package pipe_pkg;

    // ------------------------------------------------------------
    // word and bus types
    // ------------------------------------------------------------

    // bit 8 flag, bits 7..0 byte
    typedef logic [8:0]  pipe_data_t;

    typedef logic [3:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    typedef logic [3:0]  wb_sel_t;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------

    localparam wb_adr_t ADR_CORE_ID      = 4'd0;
    localparam wb_adr_t ADR_CORE_VERSION = 4'd1;
    localparam wb_adr_t ADR_DATA         = 4'd4;
    localparam wb_adr_t ADR_STATUS       = 4'd5;
    localparam wb_adr_t ADR_IRQ_EN       = 4'd6;

    localparam wb_dat_t CORE_ID      = 32'h527a_ffff;
    localparam wb_dat_t CORE_VERSION = 32'h0001_0000;

    // start + 9 data + stop
    localparam int FRAME_BITS = 11;

    // ------------------------------------------------------------
    // state machines
    // ------------------------------------------------------------

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// File: design/pipe_bit_timer.sv
`timescale 1ns/1ps

module pipe_bit_timer #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic clk,
    input  logic s_wb_rst_i,
    input  logic enable_i,
    input  logic restart_i,
    output logic tick_o,
    output logic mid_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_BIT - 1);

    // counter value half a period after a reload
    localparam logic [CNT_W-1:0] MID_CNT = CNT_W'(CLKS_PER_BIT - CLKS_PER_BIT / 2);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            cnt <= RELOAD;
        end else if (restart_i) begin
            cnt <= RELOAD;
        end else if (enable_i) begin
            if (cnt == '0) begin
                cnt <= RELOAD;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // end of bit period
    assign tick_o = enable_i && (cnt == '0);

    // bit center, repeats once per period after the first
    assign mid_o = enable_i && (cnt == MID_CNT);

endmodule

// File: design/pipe_fifo.sv
`timescale 1ns/1ps

module pipe_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  logic                 clk,
    input  logic                 s_wb_rst_i,

    input  pipe_pkg::pipe_data_t s_data_i,
    input  logic                 s_valid_i,
    output logic                 s_ready_o,

    output pipe_pkg::pipe_data_t m_data_o,
    output logic                 m_valid_o,
    input  logic                 m_ready_i,

    output logic                 empty_o
);

    localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

    pipe_pkg::pipe_data_t       mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;
    logic                       push;
    logic                       pop;

    assign s_ready_o = (count != DEPTH[FIFO_DEPTH_LOG2:0]);
    assign m_valid_o = (count != '0);
    assign empty_o   = (count == '0);

    assign push = s_valid_i && s_ready_o;
    assign pop  = m_valid_o && m_ready_i;

    // head word shown without a read cycle
    assign m_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= s_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/pipe_port.sv
`timescale 1ns/1ps

module pipe_port (
    input  logic                clk,
    input  logic                s_wb_rst_i,

    // wishbone slave
    input  pipe_pkg::wb_adr_t   s_wb_adr_i,
    input  pipe_pkg::wb_dat_t   s_wb_dat_i,
    output pipe_pkg::wb_dat_t   s_wb_dat_o,
    input  logic                s_wb_we_i,
    input  pipe_pkg::wb_sel_t   s_wb_sel_i,
    input  logic                s_wb_stb_i,
    output logic                s_wb_ack_o,
    output logic                irq_o,

    // push side of the transmit FIFO
    output pipe_pkg::pipe_data_t wr_data_o,
    output logic                wr_valid_o,
    input  logic                wr_ready_i,

    // pop side of the receive FIFO
    input  pipe_pkg::pipe_data_t rd_data_i,
    input  logic                rd_valid_i,
    output logic                rd_ready_o,

    input  logic                tx_empty_i
);

    logic       data_wr;
    logic       data_rd;
    logic       irq_en_wr;
    logic [1:0] irq_en;

    // ------------------------------------------------------------
    // access decode
    // ------------------------------------------------------------

    assign data_wr   = s_wb_stb_i && s_wb_we_i && (s_wb_adr_i == pipe_pkg::ADR_DATA);
    assign data_rd   = s_wb_stb_i && !s_wb_we_i && (s_wb_adr_i == pipe_pkg::ADR_DATA);
    assign irq_en_wr = s_wb_stb_i && s_wb_we_i && (s_wb_adr_i == pipe_pkg::ADR_IRQ_EN);

    // classic cycle, answered at once
    assign s_wb_ack_o = s_wb_stb_i;

    // a write into a full FIFO never raises valid, so it is dropped
    assign wr_data_o  = s_wb_dat_i[8:0];
    assign wr_valid_o = data_wr && wr_ready_i;

    // pop only happens when the FIFO actually has a word
    assign rd_ready_o = data_rd;

    // ------------------------------------------------------------
    // interrupt enable
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            irq_en <= 2'b00;
        end else if (irq_en_wr && s_wb_sel_i[0]) begin
            irq_en <= s_wb_dat_i[1:0];
        end
    end

    // bit 0 on tx idle, bit 1 on rx data waiting
    assign irq_o = (irq_en[0] && tx_empty_i) || (irq_en[1] && rd_valid_i);

    // ------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------

    always_comb begin
        s_wb_dat_o = '0;
        case (s_wb_adr_i)
            pipe_pkg::ADR_CORE_ID: begin
                s_wb_dat_o = pipe_pkg::CORE_ID;
            end
            pipe_pkg::ADR_CORE_VERSION: begin
                s_wb_dat_o = pipe_pkg::CORE_VERSION;
            end
            pipe_pkg::ADR_DATA: begin
                // empty FIFO reads as zero
                if (rd_valid_i) begin
                    s_wb_dat_o[8:0] = rd_data_i;
                end
            end
            pipe_pkg::ADR_STATUS: begin
                s_wb_dat_o[0] = wr_ready_i;
                s_wb_dat_o[1] = rd_valid_i;
            end
            pipe_pkg::ADR_IRQ_EN: begin
                s_wb_dat_o[1:0] = irq_en;
            end
            default: begin
                s_wb_dat_o = '0;
            end
        endcase
    end

endmodule

// File: design/pipe_serial_tx.sv
`timescale 1ns/1ps

module pipe_serial_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                 clk,
    input  logic                 s_wb_rst_i,

    input  pipe_pkg::pipe_data_t s_data_i,
    input  logic                 s_valid_i,
    output logic                 s_ready_o,

    output logic                 ser_tx_o
);

    // data bits between start and stop
    localparam int DATA_BITS = pipe_pkg::FRAME_BITS - 2;

    pipe_pkg::tx_state_e  state;
    pipe_pkg::pipe_data_t shift;
    logic [3:0]           bit_cnt;
    logic                 tick;
    logic                 accept;

    // take a new word in idle, or straight at the end of a stop bit
    assign s_ready_o = (state == pipe_pkg::TX_IDLE) || ((state == pipe_pkg::TX_STOP) && tick);
    assign accept    = s_valid_i && s_ready_o;

    pipe_bit_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_timer (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .enable_i   (state != pipe_pkg::TX_IDLE),
        .restart_i  (accept),
        .tick_o     (tick),
        .mid_o      ()
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= s_data_i;
        end else if ((state == pipe_pkg::TX_DATA) && tick) begin
            shift <= shift >> 1;
        end
    end

    // ------------------------------------------------------------
    // frame FSM, line driven from a flop
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            state    <= pipe_pkg::TX_IDLE;
            bit_cnt  <= '0;
            ser_tx_o <= 1'b1;
        end else if (accept) begin
            state    <= pipe_pkg::TX_START;
            ser_tx_o <= 1'b0;
        end else if (tick) begin
            case (state)
                pipe_pkg::TX_START: begin
                    state    <= pipe_pkg::TX_DATA;
                    bit_cnt  <= '0;
                    ser_tx_o <= shift[0];
                end
                pipe_pkg::TX_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 4'(DATA_BITS - 1)) begin
                        state    <= pipe_pkg::TX_STOP;
                        ser_tx_o <= 1'b1;
                    end else begin
                        ser_tx_o <= shift[1];
                    end
                end
                pipe_pkg::TX_STOP: begin
                    state <= pipe_pkg::TX_IDLE;
                end
                default: begin
                    state <= pipe_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/pipe_serial_rx.sv
`timescale 1ns/1ps

module pipe_serial_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                 clk,
    input  logic                 s_wb_rst_i,

    input  logic                 ser_rx_i,

    output pipe_pkg::pipe_data_t m_data_o,
    output logic                 m_valid_o
);

    localparam int DATA_BITS = pipe_pkg::FRAME_BITS - 2;

    pipe_pkg::rx_state_e  state;
    logic [1:0]           sync;
    logic                 rx_prev;
    logic                 rx_bit;
    logic                 fall;
    logic                 mid;
    logic [3:0]           bit_cnt;

    // ------------------------------------------------------------
    // input synchronizer and edge detect
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            sync    <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync    <= {sync[0], ser_rx_i};
            rx_prev <= sync[1];
        end
    end

    assign rx_bit = sync[1];
    assign fall   = rx_prev && !rx_bit;

    // timer starts over on the start-bit edge
    pipe_bit_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_timer (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .enable_i   (state != pipe_pkg::RX_IDLE),
        .restart_i  ((state == pipe_pkg::RX_IDLE) && fall),
        .tick_o     (),
        .mid_o      (mid)
    );

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if ((state == pipe_pkg::RX_DATA) && mid) begin
            m_data_o <= {rx_bit, m_data_o[8:1]};
        end
    end

    // ------------------------------------------------------------
    // receive FSM
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (s_wb_rst_i) begin
            state     <= pipe_pkg::RX_IDLE;
            bit_cnt   <= '0;
            m_valid_o <= 1'b0;
        end else begin
            m_valid_o <= 1'b0;
            case (state)
                pipe_pkg::RX_IDLE: begin
                    if (fall) begin
                        state <= pipe_pkg::RX_START;
                    end
                end
                pipe_pkg::RX_START: begin
                    // glitch shorter than half a bit goes back to idle
                    if (mid) begin
                        bit_cnt <= '0;
                        state   <= rx_bit ? pipe_pkg::RX_IDLE : pipe_pkg::RX_DATA;
                    end
                end
                pipe_pkg::RX_DATA: begin
                    if (mid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'(DATA_BITS - 1)) begin
                            state <= pipe_pkg::RX_STOP;
                        end
                    end
                end
                pipe_pkg::RX_STOP: begin
                    // bad stop bit drops the word
                    if (mid) begin
                        m_valid_o <= rx_bit;
                        state     <= pipe_pkg::RX_IDLE;
                    end
                end
                default: begin
                    state <= pipe_pkg::RX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/pipe_serial_top.sv
`timescale 1ns/1ps

module pipe_serial_top #(
    parameter int CLKS_PER_BIT    = 8,
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  logic              clk,
    input  logic              s_wb_rst_i,

    input  pipe_pkg::wb_adr_t s_wb_adr_i,
    input  pipe_pkg::wb_dat_t s_wb_dat_i,
    output pipe_pkg::wb_dat_t s_wb_dat_o,
    input  logic              s_wb_we_i,
    input  pipe_pkg::wb_sel_t s_wb_sel_i,
    input  logic              s_wb_stb_i,
    output logic              s_wb_ack_o,
    output logic              irq_o,

    output logic              ser_tx_o,
    input  logic              ser_rx_i
);

    // port to tx FIFO
    pipe_pkg::pipe_data_t wr_data;
    logic                 wr_valid;
    logic                 wr_ready;

    // tx FIFO to transmitter
    pipe_pkg::pipe_data_t tx_data;
    logic                 tx_valid;
    logic                 tx_ready;
    logic                 tx_empty;

    // receiver to rx FIFO
    pipe_pkg::pipe_data_t rx_data;
    logic                 rx_valid;

    // rx FIFO to port
    pipe_pkg::pipe_data_t rd_data;
    logic                 rd_valid;
    logic                 rd_ready;

    pipe_port u_port (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_we_i  (s_wb_we_i),
        .s_wb_sel_i (s_wb_sel_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_ack_o (s_wb_ack_o),
        .irq_o      (irq_o),
        .wr_data_o  (wr_data),
        .wr_valid_o (wr_valid),
        .wr_ready_i (wr_ready),
        .rd_data_i  (rd_data),
        .rd_valid_i (rd_valid),
        .rd_ready_o (rd_ready),
        .tx_empty_i (tx_empty)
    );

    pipe_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) tx_fifo (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .s_data_i   (wr_data),
        .s_valid_i  (wr_valid),
        .s_ready_o  (wr_ready),
        .m_data_o   (tx_data),
        .m_valid_o  (tx_valid),
        .m_ready_i  (tx_ready),
        .empty_o    (tx_empty)
    );

    pipe_serial_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .s_data_i   (tx_data),
        .s_valid_i  (tx_valid),
        .s_ready_o  (tx_ready),
        .ser_tx_o   (ser_tx_o)
    );

    pipe_serial_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .ser_rx_i   (ser_rx_i),
        .m_data_o   (rx_data),
        .m_valid_o  (rx_valid)
    );

    // receiver has no back-pressure, a full FIFO loses the word
    pipe_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) rx_fifo (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .s_data_i   (rx_data),
        .s_valid_i  (rx_valid),
        .s_ready_o  (),
        .m_data_o   (rd_data),
        .m_valid_o  (rd_valid),
        .m_ready_i  (rd_ready),
        .empty_o    ()
    );

endmodule

// File: tests/pipe_serial_tb.sv
`timescale 1ns/1ps

module pipe_serial_tb;

    localparam int CLKS_PER_BIT    = 8;
    localparam int FIFO_DEPTH_LOG2 = 2;
    localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_LOG2;
    localparam int NUM_BURSTS      = 6;

    // single words of tests 3, 5 and 6 plus the largest possible bursts
    localparam int TOTAL_WORDS     = 5 + NUM_BURSTS * FIFO_DEPTH;
    localparam int WATCHDOG_CYCLES =
        TOTAL_WORDS * pipe_pkg::FRAME_BITS * CLKS_PER_BIT * 4 + 2000;

    logic              clk;
    logic              s_wb_rst_i;
    pipe_pkg::wb_adr_t s_wb_adr_i;
    pipe_pkg::wb_dat_t s_wb_dat_i;
    pipe_pkg::wb_dat_t s_wb_dat_o;
    logic              s_wb_we_i;
    pipe_pkg::wb_sel_t s_wb_sel_i;
    logic              s_wb_stb_i;
    logic              s_wb_ack_o;
    logic              irq_o;
    logic              ser_line;

    // reference model state
    pipe_pkg::pipe_data_t model_q [$];
    logic [1:0]           irq_en_m;

    pipe_serial_top #(
        .CLKS_PER_BIT    (CLKS_PER_BIT),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) uut (
        .clk        (clk),
        .s_wb_rst_i (s_wb_rst_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_we_i  (s_wb_we_i),
        .s_wb_sel_i (s_wb_sel_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_ack_o (s_wb_ack_o),
        .irq_o      (irq_o),
        .ser_tx_o   (ser_line),
        .ser_rx_i   (ser_line)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: no progress after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    // register contents when the serial path is quiet
    function automatic pipe_pkg::wb_dat_t expected_read(input pipe_pkg::wb_adr_t adr);
        pipe_pkg::wb_dat_t value;
        value = '0;
        case (adr)
            pipe_pkg::ADR_CORE_ID:      value = pipe_pkg::CORE_ID;
            pipe_pkg::ADR_CORE_VERSION: value = pipe_pkg::CORE_VERSION;
            pipe_pkg::ADR_DATA: begin
                if (model_q.size() != 0) begin
                    value[8:0] = model_q[0];
                end
            end
            pipe_pkg::ADR_STATUS: begin
                value[0] = 1'b1;
                value[1] = (model_q.size() != 0);
            end
            pipe_pkg::ADR_IRQ_EN:       value[1:0] = irq_en_m;
            default:                    value = '0;
        endcase
        return value;
    endfunction

    // tx FIFO is empty whenever the path is quiet
    function automatic logic expected_irq();
        return irq_en_m[0] || (irq_en_m[1] && (model_q.size() != 0));
    endfunction

    function automatic pipe_pkg::pipe_data_t random_word();
        return pipe_pkg::pipe_data_t'($urandom & 32'h1ff);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string msg);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
                     $time, msg, got, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // bus tasks
    // ------------------------------------------------------------

    task automatic wb_write(input pipe_pkg::wb_adr_t adr, input pipe_pkg::wb_dat_t dat,
                            input pipe_pkg::wb_sel_t sel);
        @(posedge clk);
        s_wb_adr_i <= adr;
        s_wb_dat_i <= dat;
        s_wb_sel_i <= sel;
        s_wb_we_i  <= 1'b1;
        s_wb_stb_i <= 1'b1;
        @(negedge clk);
        check_value(32'(s_wb_ack_o), 32'd1, "write ack");
        @(posedge clk);
        s_wb_stb_i <= 1'b0;
        s_wb_we_i  <= 1'b0;
    endtask

    task automatic wb_read(input pipe_pkg::wb_adr_t adr, output pipe_pkg::wb_dat_t dat);
        @(posedge clk);
        s_wb_adr_i <= adr;
        s_wb_sel_i <= 4'hf;
        s_wb_we_i  <= 1'b0;
        s_wb_stb_i <= 1'b1;
        @(negedge clk);
        check_value(32'(s_wb_ack_o), 32'd1, "read ack");
        dat = s_wb_dat_o;
        // a DATA read pops on this edge
        @(posedge clk);
        s_wb_stb_i <= 1'b0;
    endtask

    task automatic check_reg(input pipe_pkg::wb_adr_t adr, input string msg);
        pipe_pkg::wb_dat_t got;
        wb_read(adr, got);
        check_value(got, expected_read(adr), msg);
    endtask

    task automatic set_irq_en(input logic [1:0] en);
        wb_write(pipe_pkg::ADR_IRQ_EN, {30'(($urandom >> 2)), en}, 4'h1);
        irq_en_m = en;
    endtask

    // upper bits are noise, only bits 8..0 are pushed
    task automatic send_word(input pipe_pkg::pipe_data_t w);
        wb_write(pipe_pkg::ADR_DATA, ($urandom & 32'hffff_fe00) | 32'(w), 4'hf);
    endtask

    task automatic wait_rx_word();
        pipe_pkg::wb_dat_t st;
        do begin
            wb_read(pipe_pkg::ADR_STATUS, st);
        end while (!st[1]);
    endtask

    task automatic read_next_word();
        wait_rx_word();
        check_reg(pipe_pkg::ADR_DATA, "looped-back word");
        void'(model_q.pop_front());
    endtask

    task automatic transfer_word();
        pipe_pkg::pipe_data_t w;
        w = random_word();
        send_word(w);
        model_q.push_back(w);
        read_next_word();
        check_reg(pipe_pkg::ADR_STATUS, "status after transfer");
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    initial begin
        pipe_pkg::wb_dat_t    st;
        pipe_pkg::pipe_data_t w;
        int                   burst_len;

        s_wb_rst_i  = 1'b1;
        s_wb_adr_i  = '0;
        s_wb_dat_i  = '0;
        s_wb_we_i   = 1'b0;
        s_wb_sel_i  = '0;
        s_wb_stb_i  = 1'b0;
        irq_en_m    = 2'b00;
        void'($urandom(57));

        repeat (10) @(posedge clk);
        s_wb_rst_i <= 1'b0;

        // id registers and idle status
        check_reg(pipe_pkg::ADR_CORE_ID, "core id");
        check_reg(pipe_pkg::ADR_CORE_VERSION, "core version");
        check_reg(pipe_pkg::ADR_STATUS, "status after reset");
        @(negedge clk);
        check_value(32'(irq_o), 32'(expected_irq()), "irq after reset");

        // enable register with and without sel bit 0
        set_irq_en(2'b11);
        check_reg(pipe_pkg::ADR_IRQ_EN, "irq enable write");
        wb_write(pipe_pkg::ADR_IRQ_EN, 32'h0000_0001, 4'he);
        check_reg(pipe_pkg::ADR_IRQ_EN, "irq enable masked write");
        set_irq_en(2'b00);
        check_reg(pipe_pkg::ADR_IRQ_EN, "irq enable cleared");

        transfer_word();

        // bursts, each write gated by the not-full flag
        for (int b = 0; b < NUM_BURSTS; b++) begin
            burst_len = 1 + int'($urandom % FIFO_DEPTH);
            for (int i = 0; i < burst_len; i++) begin
                wb_read(pipe_pkg::ADR_STATUS, st);
                w = random_word();
                send_word(w);
                if (st[0]) begin
                    model_q.push_back(w);
                end
            end
            while (model_q.size() != 0) begin
                read_next_word();
            end
            check_reg(pipe_pkg::ADR_STATUS, "status after burst");
        end

        // tx idle interrupt
        set_irq_en(2'b01);
        @(negedge clk);
        check_value(32'(irq_o), 32'(expected_irq()), "irq on tx idle");
        transfer_word();
        @(negedge clk);
        check_value(32'(irq_o), 32'(expected_irq()), "irq on tx idle after transfer");

        // rx data interrupt
        set_irq_en(2'b10);
        @(negedge clk);
        check_value(32'(irq_o), 32'(expected_irq()), "irq before rx word");
        w = random_word();
        send_word(w);
        model_q.push_back(w);
        do begin
            @(negedge clk);
        end while (!irq_o);
        check_reg(pipe_pkg::ADR_STATUS, "status at rx irq");
        check_reg(pipe_pkg::ADR_DATA, "word at rx irq");
        void'(model_q.pop_front());
        @(negedge clk);
        check_value(32'(irq_o), 32'(expected_irq()), "irq after rx read");

        // interrupts disabled
        set_irq_en(2'b00);
        w = random_word();
        send_word(w);
        model_q.push_back(w);
        do begin
            wb_read(pipe_pkg::ADR_STATUS, st);
            @(negedge clk);
            check_value(32'(irq_o), 32'd0, "irq while disabled");
        end while (!st[1]);
        check_reg(pipe_pkg::ADR_DATA, "word with irq disabled");
        void'(model_q.pop_front());

        // empty read, then a normal transfer
        check_reg(pipe_pkg::ADR_DATA, "empty data read");
        transfer_word();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: pipe_serial.f
design/pipe_pkg.sv
design/pipe_bit_timer.sv
design/pipe_fifo.sv
design/pipe_port.sv
design/pipe_serial_tx.sv
design/pipe_serial_rx.sv
design/pipe_serial_top.sv
tests/pipe_serial_tb.sv

// File: run_sim.sh
#!/bin/sh
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --top-module pipe_serial_tb \
    -f pipe_serial.f -o sim_pipe_serial > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_pipe_serial > "$LOG" 2>&1
cat "$LOG"

grep -q "Simulation failed" "$LOG" && { echo "run failed"; exit 1; } || exit 0
